//--- common/uartRxPkg.sv
// Shared constants for the UART receive path
// FIFO word field layout and 16x oversampling timing
package uartRxPkg;

    // FIFO word: 8 data bits plus 3 error flags
    localparam int RX_WORD_W  = 11;
    localparam int DATA_LSB   = 0;
    localparam int DATA_MSB   = 7;
    localparam int PE_BIT     = 8;    // Parity error
    localparam int FE_BIT     = 9;    // Framing error
    localparam int BI_BIT     = 10;   // Break indication

    // Receiver sampling
    localparam int OVERSAMPLE = 16;   // Ticks per bit
    localparam int MID_SAMPLE = 7;    // Start bit check point

    // Width of the software baud divisor
    localparam int DIV_W      = 16;

endpackage

//--- hdl/baudTick.sv
// 16x oversampling strobe for the receiver
// One CLK-wide tick every divisor cycles, divisor at least 2
`timescale 1ns/1ps

module baudTick (
    input  logic                        CLK,
    input  logic                        RST,
    input  logic [uartRxPkg::DIV_W-1:0] divisor,  // CLK cycles per tick
    output logic                        tick      // 16x strobe
);
    import uartRxPkg::*;

    logic [DIV_W-1:0] cnt;  // Down-counter, reload at zero

    // New divisor only picked up on reload
    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else begin
            if (cnt == '0) begin
                cnt  <= divisor - 1'b1;  // Period of divisor cycles
                tick <= 1'b1;
            end else begin
                cnt  <= cnt - 1'b1;
                tick <= 1'b0;
            end
        end
    end

endmodule

//--- uartRx/uartRx.sv
// UART receiver, 8 data bits, optional parity, one stop bit
// Samples the line at mid-bit from the 16x tick and writes one flagged word per frame
`timescale 1ns/1ps

module uartRx (
    input  logic                            CLK,
    input  logic                            RST,
    input  logic                            tick,        // 16x oversampling strobe
    input  logic                            rxd,         // Serial line, idle high
    input  logic                            parityEn,
    input  logic                            parityEven,
    output logic [uartRxPkg::RX_WORD_W-1:0] wrWord,      // Data plus PE/FE/BI
    output logic                            wrStrobe     // One-cycle FIFO write
);
    import uartRxPkg::*;

    localparam int DATA_W = DATA_MSB - DATA_LSB + 1;
    localparam int TCW    = $clog2(OVERSAMPLE);
    localparam int BCW    = $clog2(DATA_W);

    // FSM encoding
    localparam logic [2:0] S_IDLE   = 3'd0;
    localparam logic [2:0] S_START  = 3'd1;
    localparam logic [2:0] S_DATA   = 3'd2;
    localparam logic [2:0] S_PARITY = 3'd3;
    localparam logic [2:0] S_STOP   = 3'd4;
    localparam logic [2:0] S_BREAK  = 3'd5;  // Wait for line high

    logic [1:0]        rxSync;    // 2-flop synchronizer
    logic              rxS;       // Synchronized line
    logic              rxPrev;    // For falling edge
    logic [2:0]        state;
    logic [TCW-1:0]    tickCnt;   // Ticks since last sample
    logic [BCW-1:0]    bitCnt;    // Data bit index
    logic [DATA_W-1:0] shiftReg;
    logic              parAcc;    // XOR of data bits
    logic              allZero;   // Every sampled bit low so far
    logic              peFlag;
    logic              bitTick;   // Sample point of current bit
    logic              breakNow;

    assign rxS = rxSync[1];

    // Start bit checked at mid-bit, later bits a full bit apart
    assign bitTick = tick && (tickCnt == ((state == S_START) ? TCW'(MID_SAMPLE)
                                                             : TCW'(OVERSAMPLE - 1)));

    // Data, parity and stop all low
    assign breakNow = allZero && !rxS;

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            rxSync   <= 2'b11;  // Line idles high
            rxPrev   <= 1'b1;
            state    <= S_IDLE;
            tickCnt  <= '0;
            bitCnt   <= '0;
            parAcc   <= 1'b0;
            allZero  <= 1'b0;
            peFlag   <= 1'b0;
            wrStrobe <= 1'b0;
        end else begin
            rxSync   <= {rxSync[0], rxd};
            rxPrev   <= rxS;
            wrStrobe <= 1'b0;  // Pulse only
            if (tick && state != S_IDLE) begin
                tickCnt <= bitTick ? '0 : tickCnt + 1'b1;
            end
            case (state)
                S_IDLE: begin
                    tickCnt <= '0;
                    if (rxPrev && !rxS) begin  // Falling edge, start hunt
                        state <= S_START;
                    end
                end
                S_START: begin
                    if (bitTick) begin
                        bitCnt  <= '0;
                        parAcc  <= 1'b0;
                        allZero <= 1'b1;
                        peFlag  <= 1'b0;
                        state   <= rxS ? S_IDLE : S_DATA;  // Glitch back to idle
                    end
                end
                S_DATA: begin
                    if (bitTick) begin
                        parAcc  <= parAcc ^ rxS;
                        allZero <= allZero & !rxS;
                        bitCnt  <= bitCnt + 1'b1;
                        if (bitCnt == BCW'(DATA_W - 1)) begin
                            state <= parityEn ? S_PARITY : S_STOP;
                        end
                    end
                end
                S_PARITY: begin
                    if (bitTick) begin
                        // Even: total ones even; odd: total ones odd
                        peFlag  <= parAcc ^ rxS ^ !parityEven;
                        allZero <= allZero & !rxS;
                        state   <= S_STOP;
                    end
                end
                S_STOP: begin
                    if (bitTick) begin
                        wrStrobe <= 1'b1;
                        state    <= breakNow ? S_BREAK : S_IDLE;
                    end
                end
                S_BREAK: begin
                    if (rxS) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Data path, LSB first
    always_ff @(posedge CLK) begin
        if (state == S_DATA && bitTick) begin
            shiftReg <= {rxS, shiftReg[DATA_W-1:1]};
        end
        if (state == S_STOP && bitTick) begin
            wrWord[DATA_MSB:DATA_LSB] <= shiftReg;       // Zero on break
            wrWord[PE_BIT]            <= peFlag && !breakNow;
            wrWord[FE_BIT]            <= !rxS;           // Stop bit low
            wrWord[BI_BIT]            <= breakNow;
        end
    end

    // One write per frame, never back to back
    wrStrobeSingle: assert property (@(posedge CLK) disable iff (RST)
        wrStrobe |=> !wrStrobe);

endmodule

//--- rxFifo/rxFifo.sv
// Receive FIFO with registered read data
// Extra pointer wrap bit tells full from empty, level is the pointer difference
`timescale 1ns/1ps

module rxFifo #(
    parameter int FIFO_AW = 4   // log2 of depth
) (
    input  logic                            CLK,
    input  logic                            RST,
    input  logic                            clear,   // Empty the FIFO
    input  logic                            write,
    input  logic                            read,
    input  logic [uartRxPkg::RX_WORD_W-1:0] d,
    output logic [uartRxPkg::RX_WORD_W-1:0] q,       // Head word
    output logic                            empty,   // Registered
    output logic                            full,
    output logic [FIFO_AW:0]                level
);
    import uartRxPkg::*;

    localparam int DEPTH = 2 ** FIFO_AW;

    logic [RX_WORD_W-1:0] mem [DEPTH];
    logic [FIFO_AW:0]     wrPtr;   // MSB is wrap bit
    logic [FIFO_AW:0]     rdPtr;
    logic                 wrOk;
    logic                 rdOk;

    // Same slot, opposite lap
    assign full  = (wrPtr[FIFO_AW-1:0] == rdPtr[FIFO_AW-1:0]) &&
                   (wrPtr[FIFO_AW] != rdPtr[FIFO_AW]);
    assign wrOk  = write && !full;   // Write while full is dropped
    assign rdOk  = read && !empty;
    assign level = wrPtr - rdPtr;    // Handles simultaneous read and write

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            wrPtr <= '0;
            rdPtr <= '0;
            empty <= 1'b1;
        end else begin
            if (clear) begin
                wrPtr <= '0;
                rdPtr <= '0;
                empty <= 1'b1;
            end else begin
                if (wrOk) begin
                    wrPtr <= wrPtr + 1'b1;
                end
                if (rdOk) begin
                    rdPtr <= rdPtr + 1'b1;
                end
                empty <= (wrPtr == rdPtr);  // One cycle behind pointers
            end
        end
    end

    // Storage and registered head
    always_ff @(posedge CLK) begin
        if (wrOk) begin
            mem[wrPtr[FIFO_AW-1:0]] <= d;
        end
        q <= mem[rdPtr[FIFO_AW-1:0]];
    end

    levelBound: assert property (@(posedge CLK) disable iff (RST)
        level <= (FIFO_AW + 1)'(DEPTH));

endmodule

//--- hdl/rxHost.sv
// Host read side of the receive FIFO
// Splits the head word, gates pops, latches overrun and tracks flagged words
`timescale 1ns/1ps

module rxHost #(
    parameter int FIFO_AW = 4
) (
    input  logic                            CLK,
    input  logic                            RST,
    input  logic                            rdStrobe,   // Host read pulse
    input  logic                            lsrRead,    // Clears overrun
    input  logic                            fifoClear,
    input  logic                            wrStrobe,   // Receiver write
    input  logic [uartRxPkg::RX_WORD_W-1:0] wrWord,
    input  logic [uartRxPkg::RX_WORD_W-1:0] headWord,
    input  logic                            empty,
    input  logic                            full,
    output logic                            rdPop,
    output logic [uartRxPkg::DATA_MSB-uartRxPkg::DATA_LSB:0] rxData,
    output logic                            parityErr,
    output logic                            frameErr,
    output logic                            breakInt,
    output logic                            dataReady,
    output logic                            overrun,
    output logic                            fifoError   // Some stored word flagged
);
    import uartRxPkg::*;

    logic             popPrev;   // Pop in previous cycle
    logic [FIFO_AW:0] errCnt;    // Flagged words in FIFO
    logic             errIn;     // Accepted flagged write
    logic             errOut;    // Flagged head popped

    // Head word fields
    assign rxData    = headWord[DATA_MSB:DATA_LSB];
    assign parityErr = headWord[PE_BIT];
    assign frameErr  = headWord[FE_BIT];
    assign breakInt  = headWord[BI_BIT];

    assign dataReady = !empty;
    assign rdPop     = rdStrobe && dataReady && !popPrev;  // Covers stale empty
    assign fifoError = (errCnt != '0);

    assign errIn  = wrStrobe && !full &&
                    (wrWord[PE_BIT] || wrWord[FE_BIT] || wrWord[BI_BIT]);
    assign errOut = rdPop && (parityErr || frameErr || breakInt);

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            popPrev <= 1'b0;
            overrun <= 1'b0;
            errCnt  <= '0;
        end else begin
            popPrev <= rdPop;
            if (wrStrobe && full) begin
                overrun <= 1'b1;    // Set wins over clear
            end else if (lsrRead) begin
                overrun <= 1'b0;
            end
            if (fifoClear) begin
                errCnt <= '0;
            end else if (errIn && !errOut) begin
                errCnt <= errCnt + 1'b1;
            end else if (errOut && !errIn) begin
                errCnt <= errCnt - 1'b1;
            end
        end
    end

    // Pops only from a non-empty FIFO, never back to back
    popSafe: assert property (@(posedge CLK) disable iff (RST)
        rdPop |-> !empty ##1 !rdPop);

endmodule

//--- hdl/uartRxTop.sv
// Receive half of a 16550-style UART
// Baud tick, receiver, receive FIFO and host read side
`timescale 1ns/1ps

module uartRxTop #(
    parameter int FIFO_AW = 4   // FIFO depth 2**FIFO_AW
) (
    input  logic                        CLK,
    input  logic                        RST,
    input  logic                        rxd,         // Serial in, idle high
    input  logic [uartRxPkg::DIV_W-1:0] divisor,     // CLK cycles per 16x tick
    input  logic                        parityEn,
    input  logic                        parityEven,
    input  logic                        fifoClear,
    input  logic                        rdStrobe,
    input  logic                        lsrRead,
    output logic [uartRxPkg::DATA_MSB-uartRxPkg::DATA_LSB:0] rxData,
    output logic                        parityErr,
    output logic                        frameErr,
    output logic                        breakInt,
    output logic                        dataReady,
    output logic                        overrun,
    output logic                        fifoError,
    output logic [FIFO_AW:0]            rxLevel
);
    import uartRxPkg::*;

    logic                 tick;
    logic [RX_WORD_W-1:0] wrWord;     // Receiver to FIFO
    logic                 wrStrobe;
    logic [RX_WORD_W-1:0] headWord;   // FIFO head to host
    logic                 fifoEmpty;
    logic                 fifoFull;
    logic                 rdPop;

    baudTick uBaud (
        .CLK     (CLK),
        .RST     (RST),
        .divisor (divisor),
        .tick    (tick)
    );

    uartRx uRx (
        .CLK        (CLK),
        .RST        (RST),
        .tick       (tick),
        .rxd        (rxd),
        .parityEn   (parityEn),
        .parityEven (parityEven),
        .wrWord     (wrWord),
        .wrStrobe   (wrStrobe)
    );

    rxFifo #(.FIFO_AW(FIFO_AW)) uFifo (
        .CLK   (CLK),
        .RST   (RST),
        .clear (fifoClear),
        .write (wrStrobe),
        .read  (rdPop),
        .d     (wrWord),
        .q     (headWord),
        .empty (fifoEmpty),
        .full  (fifoFull),
        .level (rxLevel)
    );

    rxHost #(.FIFO_AW(FIFO_AW)) uHost (
        .CLK       (CLK),
        .RST       (RST),
        .rdStrobe  (rdStrobe),
        .lsrRead   (lsrRead),
        .fifoClear (fifoClear),
        .wrStrobe  (wrStrobe),
        .wrWord    (wrWord),
        .headWord  (headWord),
        .empty     (fifoEmpty),
        .full      (fifoFull),
        .rdPop     (rdPop),
        .rxData    (rxData),
        .parityErr (parityErr),
        .frameErr  (frameErr),
        .breakInt  (breakInt),
        .dataReady (dataReady),
        .overrun   (overrun),
        .fifoError (fifoError)
    );

endmodule

//--- verification/uartRxTb.sv
// Testbench for the UART receive subsystem
// Serializes frames from the vector file onto rxd, reads words back and checks them
`timescale 1ns/1ps

module uartRxTb;
    import uartRxPkg::*;

    localparam int FIFO_AW   = 4;
    localparam int DIV       = 4;                  // CLK cycles per 16x tick
    localparam int BIT_CYC   = DIV * OVERSAMPLE;   // CLK cycles per serial bit
    localparam int FRAME_CYC = 11 * BIT_CYC;       // Longest frame

    logic                   CLK;
    logic                   RST;
    logic                   rxd;
    logic [DIV_W-1:0]       divisor;
    logic                   parityEn;
    logic                   parityEven;
    logic                   fifoClear;
    logic                   rdStrobe;
    logic                   lsrRead;
    logic [DATA_MSB-DATA_LSB:0] rxData;
    logic                   parityErr;
    logic                   frameErr;
    logic                   breakInt;
    logic                   dataReady;
    logic                   overrun;
    logic                   fifoError;
    logic [FIFO_AW:0]       rxLevel;

    int    passCnt;
    int    failCnt;
    int    testNo;     // Running test index for names
    int    seed;       // Idle gap generator
    string vecs[$];    // Command lines from the vector file

    uartRxTop #(.FIFO_AW(FIFO_AW)) u_dut (
        .CLK(CLK), .RST(RST), .rxd(rxd), .divisor(divisor),
        .parityEn(parityEn), .parityEven(parityEven), .fifoClear(fifoClear),
        .rdStrobe(rdStrobe), .lsrRead(lsrRead), .rxData(rxData),
        .parityErr(parityErr), .frameErr(frameErr), .breakInt(breakInt),
        .dataReady(dataReady), .overrun(overrun), .fifoError(fifoError),
        .rxLevel(rxLevel)
    );

    always #2 CLK = ~CLK;  // 4 ns period

    task automatic checkData(input string name, input logic [DATA_MSB-DATA_LSB:0] exp,
                             input logic [DATA_MSB-DATA_LSB:0] act);
        if (act === exp) begin
            passCnt++;
            $display("ok     %s = %h", name, act);
        end else begin
            failCnt++;
            $display("FAILED %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic checkFlag(input string name, input logic exp, input logic act);
        if (act === exp) begin
            passCnt++;
            $display("ok     %s = %b", name, act);
        end else begin
            failCnt++;
            $display("FAILED %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic checkLevel(input string name, input logic [FIFO_AW:0] exp,
                              input logic [FIFO_AW:0] act);
        if (act === exp) begin
            passCnt++;
            $display("ok     %s = %0d", name, act);
        end else begin
            failCnt++;
            $display("FAILED %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    // Hold one serial bit for a full bit time
    task automatic sendBit(input logic v);
        rxd <= v;
        repeat (BIT_CYC) @(posedge CLK);
    endtask

    task automatic sendFrame(input logic [7:0] data, input logic pEn, input logic pEven,
                             input logic badPar, input logic badStop, input logic brk);
        logic [7:0] bits;
        logic       par;
        int         i;
        int         gap;
        bits = brk ? 8'h00 : data;
        par  = pEven ? ^data : ~^data;  // Total ones even or odd
        @(posedge CLK);
        parityEn   <= pEn;
        parityEven <= pEven;
        sendBit(1'b0);                  // Start
        for (i = 0; i < 8; i++) begin
            sendBit(bits[i]);           // LSB first
        end
        if (pEn) begin
            sendBit(brk ? 1'b0 : par ^ badPar);
        end
        sendBit(!(badStop || brk));     // Stop bit
        rxd <= 1'b1;
        if (badStop || brk) begin
            repeat (BIT_CYC) @(posedge CLK);  // Mark time so next start edge is seen
        end
        gap = $random(seed) & 31;
        repeat (gap) @(posedge CLK);
    endtask

    // Poll dataReady between edges for up to two frame times
    task automatic waitReady(output logic ok);
        int cnt;
        cnt = 0;
        @(negedge CLK);
        while (!dataReady && cnt < 2 * FRAME_CYC) begin
            @(negedge CLK);
            cnt++;
        end
        ok = dataReady;
        if (!ok) begin
            failCnt++;
            $display("Read %0d: no word became ready in time", testNo);
        end
    endtask

    task automatic readWord(input logic [7:0] data, input logic pe, input logic fe,
                            input logic bi, input logic ferr);
        logic  ok;
        string tag;
        testNo++;
        tag = $sformatf("read%0d", testNo);
        waitReady(ok);
        if (ok) begin
            checkData({tag, " data"}, data, rxData);
            checkFlag({tag, " PE"}, pe, parityErr);
            checkFlag({tag, " FE"}, fe, frameErr);
            checkFlag({tag, " BI"}, bi, breakInt);
            if (pe || fe || bi) begin
                checkFlag({tag, " fifoError before pop"}, 1'b1, fifoError);
            end
        end
        @(posedge CLK);
        rdStrobe <= 1'b1;
        @(posedge CLK);
        rdStrobe <= 1'b0;
        repeat (2) @(posedge CLK);      // Head and empty settle after pop
        @(negedge CLK);
        checkFlag({tag, " fifoError after pop"}, ferr, fifoError);
    endtask

    initial begin
        int      fd;
        int      n;
        int      frames;
        int      k;
        int      a0, a1, a2, a3, a4, a5, a6;
        byte     c;
        string   line;
        longint  limit;
        string   tag;
        CLK = 1'b0;
        RST = 1'b1;
        rxd = 1'b1;
        divisor = DIV_W'(DIV);
        parityEn = 1'b0;
        parityEven = 1'b0;
        fifoClear = 1'b0;
        rdStrobe = 1'b0;
        lsrRead = 1'b0;
        passCnt = 0;
        failCnt = 0;
        testNo = 0;
        seed = 71;
        frames = 0;
        fd = $fopen("verification/uartRxVectors.txt", "r");
        if (fd == 0) begin
            failCnt++;
            $display("Cannot open the vector file");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 1 && line[0] != "#") begin
                    vecs.push_back(line);
                    n = $sscanf(line, "%c %h %h %h %h %h %h %h",
                                c, a0, a1, a2, a3, a4, a5, a6);
                    if (c == "F") begin
                        frames += a6;   // Frame repeat count
                    end
                end
            end
            $fclose(fd);
        end
        // Frame time doubled plus reset
        limit = 2 * longint'(frames) * FRAME_CYC * 4 + 10 * 4 * 2;
        fork
            begin
                #(limit);
                $display("Watchdog: run exceeded %0d ns before the vectors finished", limit);
                $display("TEST FAILED");
                $finish;
            end
        join_none
        repeat (10) @(posedge CLK);
        RST <= 1'b0;
        repeat (4) @(posedge CLK);
        foreach (vecs[i]) begin
            n = $sscanf(vecs[i], "%c %h %h %h %h %h %h %h", c, a0, a1, a2, a3, a4, a5, a6);
            case (c)
                "F": for (k = 0; k < a6; k++) begin
                    sendFrame(8'(a0 + k), a1[0], a2[0], a3[0], a4[0], a5[0]);
                end
                "R": for (k = 0; k < a5; k++) begin
                    readWord(8'(a0 + k), a1[0], a2[0], a3[0], a4[0]);
                end
                "L": begin
                    @(negedge CLK);
                    testNo++;
                    checkLevel($sformatf("level%0d", testNo), a0[FIFO_AW:0], rxLevel);
                end
                "O": begin
                    @(negedge CLK);
                    testNo++;
                    tag = $sformatf("overrun%0d", testNo);
                    checkFlag(tag, a0[0], overrun);
                    @(posedge CLK);
                    lsrRead <= 1'b1;
                    @(posedge CLK);
                    lsrRead <= 1'b0;
                    repeat (2) @(posedge CLK);
                    @(negedge CLK);
                    checkFlag({tag, " after lsrRead"}, 1'b0, overrun);
                end
                "C": begin
                    @(posedge CLK);
                    fifoClear <= 1'b1;
                    @(posedge CLK);
                    fifoClear <= 1'b0;
                    repeat (2) @(posedge CLK);
                    @(negedge CLK);
                    testNo++;
                    tag = $sformatf("clear%0d", testNo);
                    checkFlag({tag, " dataReady"}, 1'b0, dataReady);
                    checkLevel({tag, " rxLevel"}, '0, rxLevel);
                    checkFlag({tag, " fifoError"}, 1'b0, fifoError);
                end
                default: begin
                    failCnt++;
                    $display("Unknown command in vector line %0d", i);
                end
            endcase
        end
        $display("Checks passed %0d, failed %0d", passCnt, failCnt);
        if (failCnt == 0 && passCnt > 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- all.f
common/uartRxPkg.sv
hdl/baudTick.sv
uartRx/uartRx.sv
rxFifo/rxFifo.sv
hdl/rxHost.sv
hdl/uartRxTop.sv
verification/uartRxTb.sv

//--- verification/uartRxVectors.txt
# All fields hex. F data parEn parEven badPar badStop break count | R data pe fe bi fifoErrAfterPop count
# L level | O overrun (then lsrRead) | C clear
F 55 0 0 0 0 0 1
F A3 1 1 0 0 0 1
F 3C 1 0 0 0 0 1
R 55 0 0 0 0 1
R A3 0 0 0 0 1
R 3C 0 0 0 0 1
L 0
# Parity error, then framing error, then clean
F 5A 1 1 1 0 0 1
F 81 0 0 0 1 0 1
F 7E 0 0 0 0 0 1
R 5A 1 0 0 1 1
R 81 0 1 0 0 1
R 7E 0 0 0 0 1
# Break, then a normal frame
F 00 0 0 0 0 1 1
F C5 1 0 0 0 0 1
R 00 0 1 1 0 1
R C5 0 0 0 0 1
# 17 frames into a 16-deep FIFO
F 10 0 0 0 0 0 11
L 10
O 1
R 10 0 0 0 0 10
L 0
# Clear drops a flagged word
F 99 0 0 0 0 0 1
F 5A 1 1 1 0 0 1
C
F 42 1 1 0 0 0 1
R 42 0 0 0 0 1
O 0
L 0
